/* bench/core_chk.sv */
module core_chk (
  input logic                  clk,
  input logic                  rst,
  input logic                  trace_we_i,
  input rv_pkg::reg_idx_t      trace_rd_i,
  input rv_pkg::cycle_status_e trace_status_i,
  input logic                  halt_i
);
  timeunit 1ns;
  timeprecision 1ps;

  // a writing slot never targets x0
  rd_nonzero: assert property (@(posedge clk) disable iff (rst)
    trace_we_i |-> (trace_rd_i != '0))
    else $error("trace write with an rd of zero");

  // the halt flag only clears through reset
  halt_sticky: assert property (@(posedge clk)
    ($past(halt_i) && !halt_i) |-> $past(rst))
    else $error("halt fell while rst was low");

  // reset empties the writeback slot
  status_after_reset: assert property (@(posedge clk)
    $past(rst) |-> (trace_status_i == rv_pkg::cycle_reset))
    else $error("writeback slot not empty after rst");

endmodule

bind rv_result core_chk u_chk (
  .clk            (clk),
  .rst            (rst),
  .trace_we_i     (trace_we_o),
  .trace_rd_i     (trace_rd_o),
  .trace_status_i (trace_status_o),
  .halt_i         (halt_o)
);

/* bench/core_stimulus.txt */
// columns: instruction word, expected we, expected rd, expected data (all hex)
// line n is the word fetched at address 4*n; rd and data are unused when we is 0
123450B7 1 01 12345000
00001117 1 02 00001004
FFB00193 1 03 FFFFFFFB
00700213 1 04 00000007
12308293 1 05 12345123
0FF14313 1 06 000010FB
0001A393 1 07 00000001
0071B413 1 08 00000000
403204B3 1 09 0000000C
4011D513 1 0A FFFFFFFD
01C1D593 1 0B 0000000F
00421613 1 0C 00000070
4041D6B3 1 0D FFFFFFFF
0040D733 1 0E 002468A0
0041A7B3 1 0F 00000001
0041B833 1 10 00000000
00108013 0 00 00000000
0FF0000F 0 00 00000000
00000463 0 00 00000000
00002883 0 00 00000000
00500933 1 12 12345123
0050C9B3 1 13 00000123
0041FA33 1 14 00000003
00416AB3 1 15 00001007
0F01FB13 1 16 000000F0
70026B93 1 17 00000707
00421C33 1 18 00000380
00000073 0 00 00000000

/* bench/tb_core.sv */
module tb_core;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int num_entries = 28;
  localparam int stim_words = 4 * num_entries;
  localparam int wait_limit = 20;
  localparam int halt_hold = 10;
  localparam rv_pkg::word_t nop_word = 32'h0000_0013;

  logic                  clk = 1'b0;
  logic                  rst;
  rv_pkg::word_t         insn = nop_word;
  rv_pkg::word_t         pc;
  logic                  halt;
  rv_pkg::word_t         trace_pc;
  rv_pkg::word_t         trace_insn;
  rv_pkg::cycle_status_e trace_status;
  logic                  trace_we;
  rv_pkg::reg_idx_t      trace_rd;
  rv_pkg::word_t         trace_data;

  // four words per entry: insn, we, rd, data
  rv_pkg::word_t stim_mem [stim_words];
  int cycle_count;

  rv_core #(
    .reset_pc (32'h0)
  ) uut (
    .clk            (clk),
    .rst            (rst),
    .insn_i         (insn),
    .pc_o           (pc),
    .halt_o         (halt),
    .trace_pc_o     (trace_pc),
    .trace_insn_o   (trace_insn),
    .trace_status_o (trace_status),
    .trace_we_o     (trace_we),
    .trace_rd_o     (trace_rd),
    .trace_data_o   (trace_data)
  );

  always #2 clk = ~clk;

  // instruction fetch answered on the falling edge
  always @(negedge clk) begin
    insn <= fetch_word(pc);
  end

  // beyond the program the fetch sees nops
  function automatic rv_pkg::word_t fetch_word(input rv_pkg::word_t addr);
    int idx;
    idx = int'(addr >> 2);
    if (idx < num_entries) begin
      return stim_mem[4 * idx];
    end else begin
      return nop_word;
    end
  endfunction

  task automatic expect_equal(input rv_pkg::word_t actual, input rv_pkg::word_t expected,
                              input string what);
    if (actual !== expected) begin
      $display("** Error at %0t ns: %s is %h, expected %h", $time, what, actual, expected);
      $display("Done: errors found");
      $fatal(1, "stopped at the first mismatch");
    end
  endtask

  task automatic report_timeout(input string what);
    $display("Timeout at %0t ns: %s did not happen within %0d cycles",
             $time, what, wait_limit);
    $display("Done: errors found");
    $fatal(1, "stopped on a timeout");
  endtask

  // one cycle on, pc_o has moved by one word
  task automatic advance_cycle();
    @(negedge clk);
    cycle_count++;
    expect_equal(pc, 32'(4 * cycle_count), "pc_o");
  endtask

  task automatic verify_idle();
    expect_equal(32'(trace_status), 32'(rv_pkg::cycle_reset), "trace_status_o in a bubble");
    expect_equal(32'(trace_we), 32'h0, "trace_we_o in a bubble");
    expect_equal(32'(halt), 32'h0, "halt_o in a bubble");
  endtask

  task automatic compare_trace(input int idx);
    rv_pkg::word_t exp_we;
    exp_we = stim_mem[4 * idx + 1];
    expect_equal(trace_pc, 32'(4 * idx), $sformatf("trace_pc_o of entry %0d", idx));
    expect_equal(trace_insn, stim_mem[4 * idx], $sformatf("trace_insn_o of entry %0d", idx));
    expect_equal(32'(trace_status), 32'(rv_pkg::cycle_no_stall),
                 $sformatf("trace_status_o of entry %0d", idx));
    expect_equal(32'(trace_we), exp_we, $sformatf("trace_we_o of entry %0d", idx));
    if (exp_we != 0) begin
      expect_equal(32'(trace_rd), stim_mem[4 * idx + 2],
                   $sformatf("trace_rd_o of entry %0d", idx));
      expect_equal(trace_data, stim_mem[4 * idx + 3],
                   $sformatf("trace_data_o of entry %0d", idx));
    end
  endtask

  initial begin
    int waited;
    rst = 1'b1;
    cycle_count = 0;
    $readmemh("bench/core_stimulus.txt", stim_mem);

    // five rising edges under reset
    for (int i = 0; i < 5; i++) begin
      @(negedge clk);
      verify_idle();
    end
    rst = 1'b0;
    expect_equal(pc, 32'h0, "pc_o in the first cycle after reset");

    // reset bubbles drain before the first writeback
    waited = 0;
    while (trace_status != rv_pkg::cycle_no_stall) begin
      if (waited == wait_limit) begin
        report_timeout("the first writeback");
      end
      verify_idle();
      advance_cycle();
      waited++;
    end
    expect_equal(32'(cycle_count), 32'd4, "cycle of the first writeback");

    // one writeback per cycle in program order
    for (int i = 0; i < num_entries; i++) begin
      if (i > 0) begin
        advance_cycle();
      end
      compare_trace(i);
      if (i < num_entries - 1) begin
        expect_equal(32'(halt), 32'h0, "halt_o before the ecall");
      end
    end

    waited = 0;
    while (!halt) begin
      if (waited == wait_limit) begin
        report_timeout("halt_o");
      end
      advance_cycle();
      waited++;
    end
    // the ecall is the last entry, at writeback four cycles after its fetch
    expect_equal(32'(cycle_count), 32'(num_entries + 3), "cycle of halt_o");

    for (int i = 0; i < halt_hold; i++) begin
      advance_cycle();
      expect_equal(32'(halt), 32'h1, "halt_o after the ecall");
    end

    $display("Done: no errors");
    $finish;
  end

endmodule

/* build.f */
rtl/rv_pkg.sv
rtl/rv_regfile.sv
rtl/rv_decode.sv
rtl/rv_execute.sv
rtl/rv_result.sv
rtl/rv_core.sv
bench/core_chk.sv
bench/tb_core.sv

/* rtl/rv_core.sv */
module rv_core #(
  parameter rv_pkg::word_t reset_pc = '0
) (
  input  logic                  clk,
  input  logic                  rst,
  input  rv_pkg::word_t         insn_i,
  output rv_pkg::word_t         pc_o,
  output logic                  halt_o,
  output rv_pkg::word_t         trace_pc_o,
  output rv_pkg::word_t         trace_insn_o,
  output rv_pkg::cycle_status_e trace_status_o,
  output logic                  trace_we_o,
  output rv_pkg::reg_idx_t      trace_rd_o,
  output rv_pkg::word_t         trace_data_o
);

  // decode to execute
  rv_pkg::word_t         d_pc;
  rv_pkg::word_t         d_insn;
  rv_pkg::cycle_status_e d_status;
  rv_pkg::reg_idx_t      d_rd;
  logic                  d_we;
  rv_pkg::alu_op_e       d_op;
  rv_pkg::word_t         d_operand_a;
  rv_pkg::word_t         d_operand_b;
  logic                  d_halt;

  // execute to memory
  rv_pkg::word_t         x_pc;
  rv_pkg::word_t         x_insn;
  rv_pkg::cycle_status_e x_status;
  rv_pkg::reg_idx_t      x_rd;
  logic                  x_we;
  rv_pkg::word_t         x_result;
  logic                  x_halt;

  // register file write port from writeback
  logic                  wb_we;
  rv_pkg::reg_idx_t      wb_rd;
  rv_pkg::word_t         wb_data;

  rv_decode #(
    .reset_pc (reset_pc)
  ) u_decode (
    .clk           (clk),
    .rst           (rst),
    .insn_i        (insn_i),
    .wb_we_i       (wb_we),
    .wb_rd_i       (wb_rd),
    .wb_data_i     (wb_data),
    .pc_o          (pc_o),
    .d_pc_o        (d_pc),
    .d_insn_o      (d_insn),
    .d_status_o    (d_status),
    .d_rd_o        (d_rd),
    .d_we_o        (d_we),
    .d_op_o        (d_op),
    .d_operand_a_o (d_operand_a),
    .d_operand_b_o (d_operand_b),
    .d_halt_o      (d_halt)
  );

  rv_execute u_execute (
    .clk           (clk),
    .rst           (rst),
    .d_pc_i        (d_pc),
    .d_insn_i      (d_insn),
    .d_status_i    (d_status),
    .d_rd_i        (d_rd),
    .d_we_i        (d_we),
    .d_op_i        (d_op),
    .d_operand_a_i (d_operand_a),
    .d_operand_b_i (d_operand_b),
    .d_halt_i      (d_halt),
    .x_pc_o        (x_pc),
    .x_insn_o      (x_insn),
    .x_status_o    (x_status),
    .x_rd_o        (x_rd),
    .x_we_o        (x_we),
    .x_result_o    (x_result),
    .x_halt_o      (x_halt)
  );

  rv_result u_result (
    .clk            (clk),
    .rst            (rst),
    .x_pc_i         (x_pc),
    .x_insn_i       (x_insn),
    .x_status_i     (x_status),
    .x_rd_i         (x_rd),
    .x_we_i         (x_we),
    .x_result_i     (x_result),
    .x_halt_i       (x_halt),
    .wb_we_o        (wb_we),
    .wb_rd_o        (wb_rd),
    .wb_data_o      (wb_data),
    .halt_o         (halt_o),
    .trace_pc_o     (trace_pc_o),
    .trace_insn_o   (trace_insn_o),
    .trace_status_o (trace_status_o),
    .trace_we_o     (trace_we_o),
    .trace_rd_o     (trace_rd_o),
    .trace_data_o   (trace_data_o)
  );

endmodule

/* rtl/rv_decode.sv */
module rv_decode #(
  parameter rv_pkg::word_t reset_pc = '0
) (
  input  logic                  clk,
  input  logic                  rst,
  input  rv_pkg::word_t         insn_i,
  input  logic                  wb_we_i,
  input  rv_pkg::reg_idx_t      wb_rd_i,
  input  rv_pkg::word_t         wb_data_i,
  output rv_pkg::word_t         pc_o,
  output rv_pkg::word_t         d_pc_o,
  output rv_pkg::word_t         d_insn_o,
  output rv_pkg::cycle_status_e d_status_o,
  output rv_pkg::reg_idx_t      d_rd_o,
  output logic                  d_we_o,
  output rv_pkg::alu_op_e       d_op_o,
  output rv_pkg::word_t         d_operand_a_o,
  output rv_pkg::word_t         d_operand_b_o,
  output logic                  d_halt_o
);

  rv_pkg::word_t         f_pc;
  rv_pkg::word_t         d_pc;
  rv_pkg::insn_word_u    d_insn;
  rv_pkg::cycle_status_e d_status;
  rv_pkg::word_t         rs1_data;
  rv_pkg::word_t         rs2_data;
  rv_pkg::word_t         imm_i;
  rv_pkg::word_t         imm_u;
  rv_pkg::word_t         shamt;
  logic                  writes;
  logic                  is_ecall;
  logic                  slot_valid;

  // fetch pc, one word per cycle
  always_ff @(posedge clk) begin
    if (rst) begin
      f_pc <= reset_pc;
    end else begin
      f_pc <= f_pc + rv_pkg::xlen'(4);
    end
  end

  assign pc_o = f_pc;

  // fetch-to-decode register, insn_i arrives on the falling edge
  always_ff @(posedge clk) begin
    d_pc <= f_pc;
    d_insn <= insn_i;
    if (rst) begin
      d_status <= rv_pkg::cycle_reset;
    end else begin
      d_status <= rv_pkg::cycle_no_stall;
    end
  end

  rv_regfile u_regfile (
    .clk        (clk),
    .rst        (rst),
    .we_i       (wb_we_i),
    .rd_i       (wb_rd_i),
    .rd_data_i  (wb_data_i),
    .rs1_i      (d_insn.r.rs1),
    .rs2_i      (d_insn.r.rs2),
    .rs1_data_o (rs1_data),
    .rs2_data_o (rs2_data)
  );

  // I immediate sits in the funct7 and rs2 fields
  assign imm_i = {{20{d_insn.r.funct7[6]}}, d_insn.r.funct7, d_insn.r.rs2};
  assign imm_u = {d_insn.u.imm20, 12'b0};
  assign shamt = {{(rv_pkg::xlen - rv_pkg::reg_addr_w){1'b0}}, d_insn.r.rs2};

  assign is_ecall = (d_insn[31:7] == '0);

  always_comb begin
    d_op_o = rv_pkg::alu_nop;
    writes = 1'b0;
    d_operand_a_o = rs1_data;
    d_operand_b_o = rs2_data;
    case (d_insn.r.opcode)
      rv_pkg::op_lui: begin
        d_op_o = rv_pkg::alu_lui;
        writes = 1'b1;
        d_operand_a_o = '0;
        d_operand_b_o = imm_u;
      end
      rv_pkg::op_auipc: begin
        d_op_o = rv_pkg::alu_auipc;
        writes = 1'b1;
        d_operand_a_o = d_pc;
        d_operand_b_o = imm_u;
      end
      rv_pkg::op_reg_imm: begin
        writes = 1'b1;
        d_operand_b_o = imm_i;
        case (d_insn.r.funct3)
          3'b000: d_op_o = rv_pkg::alu_add;
          3'b010: d_op_o = rv_pkg::alu_slt;
          3'b011: d_op_o = rv_pkg::alu_sltu;
          3'b100: d_op_o = rv_pkg::alu_xor;
          3'b110: d_op_o = rv_pkg::alu_or;
          3'b111: d_op_o = rv_pkg::alu_and;
          3'b001: begin
            d_operand_b_o = shamt;
            if (d_insn.r.funct7 == rv_pkg::funct7_base) begin
              d_op_o = rv_pkg::alu_sll;
            end else begin
              writes = 1'b0;
            end
          end
          default: begin
            // funct3 101, right shifts
            d_operand_b_o = shamt;
            if (d_insn.r.funct7 == rv_pkg::funct7_base) begin
              d_op_o = rv_pkg::alu_srl;
            end else if (d_insn.r.funct7 == rv_pkg::funct7_alt) begin
              d_op_o = rv_pkg::alu_sra;
            end else begin
              writes = 1'b0;
            end
          end
        endcase
      end
      rv_pkg::op_reg_reg: begin
        writes = 1'b1;
        case ({d_insn.r.funct7, d_insn.r.funct3})
          {rv_pkg::funct7_base, 3'b000}: d_op_o = rv_pkg::alu_add;
          {rv_pkg::funct7_alt, 3'b000}: d_op_o = rv_pkg::alu_sub;
          {rv_pkg::funct7_base, 3'b001}: d_op_o = rv_pkg::alu_sll;
          {rv_pkg::funct7_base, 3'b010}: d_op_o = rv_pkg::alu_slt;
          {rv_pkg::funct7_base, 3'b011}: d_op_o = rv_pkg::alu_sltu;
          {rv_pkg::funct7_base, 3'b100}: d_op_o = rv_pkg::alu_xor;
          {rv_pkg::funct7_base, 3'b101}: d_op_o = rv_pkg::alu_srl;
          {rv_pkg::funct7_alt, 3'b101}: d_op_o = rv_pkg::alu_sra;
          {rv_pkg::funct7_base, 3'b110}: d_op_o = rv_pkg::alu_or;
          {rv_pkg::funct7_base, 3'b111}: d_op_o = rv_pkg::alu_and;
          // M extension and unknown encodings
          default: writes = 1'b0;
        endcase
      end
      rv_pkg::op_misc_mem: begin
        // fence has nothing to order here
        d_op_o = rv_pkg::alu_nop;
      end
      default: begin
        writes = 1'b0;
      end
    endcase
  end

  assign slot_valid = (d_status == rv_pkg::cycle_no_stall);

  assign d_pc_o = d_pc;
  assign d_insn_o = d_insn;
  assign d_status_o = d_status;
  assign d_rd_o = d_insn.r.rd;
  assign d_we_o = writes && (d_insn.r.rd != '0) && slot_valid;
  assign d_halt_o = (d_insn.r.opcode == rv_pkg::op_environ) && is_ecall && slot_valid;

endmodule

/* rtl/rv_execute.sv */
module rv_execute (
  input  logic                  clk,
  input  logic                  rst,
  input  rv_pkg::word_t         d_pc_i,
  input  rv_pkg::word_t         d_insn_i,
  input  rv_pkg::cycle_status_e d_status_i,
  input  rv_pkg::reg_idx_t      d_rd_i,
  input  logic                  d_we_i,
  input  rv_pkg::alu_op_e       d_op_i,
  input  rv_pkg::word_t         d_operand_a_i,
  input  rv_pkg::word_t         d_operand_b_i,
  input  logic                  d_halt_i,
  output rv_pkg::word_t         x_pc_o,
  output rv_pkg::word_t         x_insn_o,
  output rv_pkg::cycle_status_e x_status_o,
  output rv_pkg::reg_idx_t      x_rd_o,
  output logic                  x_we_o,
  output rv_pkg::word_t         x_result_o,
  output logic                  x_halt_o
);

  rv_pkg::alu_op_e x_op;
  rv_pkg::word_t   x_a;
  rv_pkg::word_t   x_b;
  logic [4:0]      sh;
  logic            lt_signed;
  logic            lt_unsigned;

  // payload of the decode-to-execute register
  always_ff @(posedge clk) begin
    x_pc_o <= d_pc_i;
    x_insn_o <= d_insn_i;
    x_rd_o <= d_rd_i;
    x_op <= d_op_i;
    x_a <= d_operand_a_i;
    x_b <= d_operand_b_i;
  end

  // slot control
  always_ff @(posedge clk) begin
    if (rst) begin
      x_status_o <= rv_pkg::cycle_reset;
      x_we_o <= 1'b0;
      x_halt_o <= 1'b0;
    end else begin
      x_status_o <= d_status_i;
      x_we_o <= d_we_i;
      x_halt_o <= d_halt_i;
    end
  end

  // only the low five bits shift
  assign sh = x_b[4:0];
  assign lt_signed = $signed(x_a) < $signed(x_b);
  assign lt_unsigned = x_a < x_b;

  always_comb begin
    case (x_op)
      rv_pkg::alu_add,
      rv_pkg::alu_auipc: x_result_o = x_a + x_b;
      rv_pkg::alu_sub: x_result_o = x_a - x_b;
      rv_pkg::alu_sll: x_result_o = x_a << sh;
      rv_pkg::alu_slt: x_result_o = {{(rv_pkg::xlen - 1){1'b0}}, lt_signed};
      rv_pkg::alu_sltu: x_result_o = {{(rv_pkg::xlen - 1){1'b0}}, lt_unsigned};
      rv_pkg::alu_xor: x_result_o = x_a ^ x_b;
      rv_pkg::alu_srl: x_result_o = x_a >> sh;
      rv_pkg::alu_sra: x_result_o = $signed(x_a) >>> sh;
      rv_pkg::alu_or: x_result_o = x_a | x_b;
      rv_pkg::alu_and: x_result_o = x_a & x_b;
      // upper immediate already in place
      rv_pkg::alu_lui: x_result_o = x_b;
      default: x_result_o = '0;
    endcase
  end

endmodule

/* rtl/rv_pkg.sv */
package rv_pkg;

  // register and address width
  localparam int xlen = 32;
  localparam int reg_addr_w = 5;

  typedef logic [xlen-1:0] word_t;
  typedef logic [reg_addr_w-1:0] reg_idx_t;

  // major opcodes used by the decoder
  localparam logic [6:0] op_lui = 7'b01_101_11;
  localparam logic [6:0] op_auipc = 7'b00_101_11;
  localparam logic [6:0] op_reg_imm = 7'b00_100_11;
  localparam logic [6:0] op_reg_reg = 7'b01_100_11;
  localparam logic [6:0] op_environ = 7'b11_100_11;
  localparam logic [6:0] op_misc_mem = 7'b00_011_11;

  // funct7 variants of the alu group
  localparam logic [6:0] funct7_base = 7'b000_0000;
  localparam logic [6:0] funct7_alt = 7'b010_0000;

  // what occupies a pipeline slot
  typedef enum logic [1:0] {
    cycle_reset = 2'd0,
    cycle_no_stall = 2'd1
  } cycle_status_e;

  typedef enum logic [3:0] {
    alu_nop,
    alu_add,
    alu_sub,
    alu_sll,
    alu_slt,
    alu_sltu,
    alu_xor,
    alu_srl,
    alu_sra,
    alu_or,
    alu_and,
    alu_lui,
    alu_auipc
  } alu_op_e;

  // register-register layout, also covers the I-type fields
  typedef struct packed {
    logic [6:0] funct7;
    reg_idx_t rs2;
    reg_idx_t rs1;
    logic [2:0] funct3;
    reg_idx_t rd;
    logic [6:0] opcode;
  } insn_r_t;

  // upper-immediate layout
  typedef struct packed {
    logic [19:0] imm20;
    reg_idx_t rd;
    logic [6:0] opcode;
  } insn_u_t;

  typedef union packed {
    insn_r_t r;
    insn_u_t u;
  } insn_word_u;

endpackage

/* rtl/rv_regfile.sv */
module rv_regfile (
  input  logic             clk,
  input  logic             rst,
  input  logic             we_i,
  input  rv_pkg::reg_idx_t rd_i,
  input  rv_pkg::word_t    rd_data_i,
  input  rv_pkg::reg_idx_t rs1_i,
  input  rv_pkg::reg_idx_t rs2_i,
  output rv_pkg::word_t    rs1_data_o,
  output rv_pkg::word_t    rs2_data_o
);

  localparam int num_regs = 2 ** rv_pkg::reg_addr_w;

  rv_pkg::word_t regs [num_regs];

  // writes to x0 are dropped
  always_ff @(posedge clk) begin
    if (rst) begin
      regs <= '{default: '0};
    end else if (we_i && (rd_i != '0)) begin
      regs[rd_i] <= rd_data_i;
    end
  end

  // combinational reads, x0 forced to zero
  always_comb begin
    if (rs1_i == '0) begin
      rs1_data_o = '0;
    end else begin
      rs1_data_o = regs[rs1_i];
    end
    if (rs2_i == '0) begin
      rs2_data_o = '0;
    end else begin
      rs2_data_o = regs[rs2_i];
    end
  end

endmodule

/* rtl/rv_result.sv */
module rv_result (
  input  logic                  clk,
  input  logic                  rst,
  input  rv_pkg::word_t         x_pc_i,
  input  rv_pkg::word_t         x_insn_i,
  input  rv_pkg::cycle_status_e x_status_i,
  input  rv_pkg::reg_idx_t      x_rd_i,
  input  logic                  x_we_i,
  input  rv_pkg::word_t         x_result_i,
  input  logic                  x_halt_i,
  output logic                  wb_we_o,
  output rv_pkg::reg_idx_t      wb_rd_o,
  output rv_pkg::word_t         wb_data_o,
  output logic                  halt_o,
  output rv_pkg::word_t         trace_pc_o,
  output rv_pkg::word_t         trace_insn_o,
  output rv_pkg::cycle_status_e trace_status_o,
  output logic                  trace_we_o,
  output rv_pkg::reg_idx_t      trace_rd_o,
  output rv_pkg::word_t         trace_data_o
);

  // memory stage
  rv_pkg::word_t         m_pc;
  rv_pkg::word_t         m_insn;
  rv_pkg::cycle_status_e m_status;
  rv_pkg::reg_idx_t      m_rd;
  logic                  m_we;
  rv_pkg::word_t         m_data;
  logic                  m_halt;

  // writeback stage
  rv_pkg::word_t         w_pc;
  rv_pkg::word_t         w_insn;
  rv_pkg::cycle_status_e w_status;
  rv_pkg::reg_idx_t      w_rd;
  logic                  w_we;
  rv_pkg::word_t         w_data;
  logic                  w_halt;

  always_ff @(posedge clk) begin
    m_pc <= x_pc_i;
    m_insn <= x_insn_i;
    m_rd <= x_rd_i;
    m_data <= x_result_i;
    w_pc <= m_pc;
    w_insn <= m_insn;
    w_rd <= m_rd;
    w_data <= m_data;
  end

  // halt is sticky once an ecall reaches writeback
  always_ff @(posedge clk) begin
    if (rst) begin
      m_status <= rv_pkg::cycle_reset;
      m_we <= 1'b0;
      m_halt <= 1'b0;
      w_status <= rv_pkg::cycle_reset;
      w_we <= 1'b0;
      w_halt <= 1'b0;
    end else begin
      m_status <= x_status_i;
      m_we <= x_we_i;
      m_halt <= x_halt_i;
      w_status <= m_status;
      w_we <= m_we;
      w_halt <= w_halt | m_halt;
    end
  end

  assign wb_we_o = w_we;
  assign wb_rd_o = w_rd;
  assign wb_data_o = w_data;
  assign halt_o = w_halt;

  assign trace_pc_o = w_pc;
  assign trace_insn_o = w_insn;
  assign trace_status_o = w_status;
  assign trace_we_o = w_we;
  assign trace_rd_o = w_rd;
  assign trace_data_o = w_data;

endmodule

/* run.sh */
#!/usr/bin/env bash
# build the core testbench with Verilator and run it from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps -j 0 \
  --top-module tb_core -f build.f -o sim_core \
  && ./obj_dir/sim_core | tee /dev/stderr | grep -q "Done: no errors" \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
